/* sim.f */
+incdir+common
common/ctrl_pkg.sv
control/opcode_decoder.sv
control/step_sequencer.sv
control/control_word_gen.sv
verilog/control_unit.sv
testbench/control_unit_chk.sv
testbench/control_unit_tb.sv

/* run_sim.sh */
#!/bin/bash
# Builds the control unit testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal --top-module control_unit_tb \
        -f sim.f -o control_unit_sim > build.log 2>&1 &&
./obj_dir/control_unit_sim > sim.log 2>&1 ||
echo "TEST FAILED" >> sim.log

cat sim.log
grep -q "TEST FAILED" sim.log && { echo "Simulation failed"; exit 1; }
echo "Simulation passed"
exit 0

/* testbench/control_unit_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "ctrl_params.svh"

module control_unit_tb import ctrl_pkg::*; ();

        typedef struct {
                instr_fields_t instr;
                alu_flags_t    flags;
                int            rand_flags;      // Flags are don't care
                int            cycles;          // Cycles between ir_write pulses or 0 for halt
                int            probe;           // Cycle of the execute step after ir_write
                ctrl_sel_t     sel;
                ctrl_wr_t      wr;
                int            pc_writes;
                int            mem_writes;
        } row_t;

        logic          clk = 1'b0;
        logic          reset;
        instr_fields_t instr;
        alu_flags_t    flags;
        ctrl_sel_t     sel;
        ctrl_wr_t      wr_ctl;

        row_t rows[$];
        int   value_errs = 0;
        int   other_errs = 0;
        int   cycle_cnt = 0;
        int   limit = 0;

        control_unit control_unit_i (
                .clk    (clk),
                .reset  (reset),
                .instr  (instr),
                .flags  (flags),
                .sel    (sel),
                .wr_ctl (wr_ctl)
        );

        always #2 clk = ~clk;

        always @(posedge clk) begin
                cycle_cnt <= cycle_cnt + 1;
                if (cycle_cnt >= limit) begin
                        $display("Timeout after %0d cycles, the table did not finish", cycle_cnt);
                        $display("TEST FAILED");
                        $finish;
                end
        end

        // st is {wr, pc_write, bank_write, epc_write with mem_reg_write}
        task automatic add_row(input logic [5:0] op, input logic [5:0] funct,
                               input logic [2:0] fl, input int rnd, input int cycles,
                               input int probe, input logic [3:0] st, input int pcw,
                               input ctrl_sel_t s);
                row_t r;
                r.instr.op         = op;
                r.instr.funct      = funct;
                r.flags            = fl;
                r.rand_flags       = rnd;
                r.cycles           = cycles;
                r.probe            = probe;
                r.sel              = s;
                r.wr               = '0;
                r.wr.wr            = st[3];
                r.wr.pc_write      = st[2];
                r.wr.bank_write    = st[1];
                r.wr.epc_write     = st[0];
                r.wr.mem_reg_write = st[0];
                r.pc_writes        = pcw;
                r.mem_writes       = st[3] ? 1 : 0;
                rows.push_back(r);
        endtask

        task automatic check_sel(input string name, input ctrl_sel_t got, exp);
                if (got !== exp) begin
                        $display("Fail at %0.1f ns: %s is %h, expected %h",
                                 $realtime, name, got, exp);
                        value_errs++;
                end
        endtask

        task automatic check_wr(input string name, input ctrl_wr_t got, exp);
                if (got !== exp) begin
                        $display("Fail at %0.1f ns: %s is %b, expected %b",
                                 $realtime, name, got, exp);
                        value_errs++;
                end
        endtask

        task automatic check_count(input string name, input int got, exp);
                if (got != exp) begin
                        $display("Fail at %0.1f ns: %s is %0d, expected %0d",
                                 $realtime, name, got, exp);
                        value_errs++;
                end
        endtask

        // Drives one row and follows it up to the next instruction load
        task automatic apply_row(input int idx);
                row_t        r;
                logic [31:0] rnd;
                logic        done;
                int          n;
                int          pcw;
                int          mw;
                ctrl_sel_t   dec_sel;
                ctrl_wr_t    dec_wr;
                r    = rows[idx];
                rnd  = $urandom;
                done = 1'b0;
                n    = 0;
                pcw  = 0;
                mw   = 0;

                // Decode step 0 loads A and B and computes the branch target
                dec_sel              = {alu_add, sa_pc, sb_offset, pc_alu_out, br_rd, bd_alu,
                                        io_pc};
                dec_wr               = '0;
                dec_wr.a_write       = 1'b1;
                dec_wr.b_write       = 1'b1;
                dec_wr.alu_out_write = 1'b1;

                @(posedge clk);
                #0.5;
                instr = r.instr;
                if (r.rand_flags != 0)
                        flags = rnd[2:0];
                else
                        flags = r.flags;
                while (!done) begin
                        @(negedge clk);
                        n++;
                        if (n == 1) begin
                                check_sel($sformatf("row %0d decode sel", idx), sel, dec_sel);
                                check_wr($sformatf("row %0d decode wr_ctl", idx), wr_ctl, dec_wr);
                        end
                        if (n == r.probe) begin
                                check_sel($sformatf("row %0d sel", idx), sel, r.sel);
                                check_wr($sformatf("row %0d wr_ctl", idx), wr_ctl, r.wr);
                        end
                        if (wr_ctl.ir_write)
                                done = 1'b1;
                        else if (r.cycles == 0 && n == 16)
                                done = 1'b1;    // Halted long enough
                        if (!wr_ctl.ir_write && wr_ctl.pc_write)
                                pcw++;
                        if (wr_ctl.wr)
                                mw++;
                end
                if (r.cycles == 0) begin
                        if (wr_ctl.ir_write) begin
                                $display("Row %0d: an instruction was fetched after break", idx);
                                other_errs++;
                        end
                end else begin
                        check_count($sformatf("row %0d cycles", idx), n, r.cycles);
                        check_count($sformatf("row %0d pc_write pulses", idx), pcw, r.pc_writes);
                        check_count($sformatf("row %0d wr pulses", idx), mw, r.mem_writes);
                end
        endtask

        initial begin
                ctrl_wr_t    load_wr;
                int          n;
                void'($urandom(41050));
                reset = 1'b1;
                instr = '0;
                flags = '0;
                load_wr          = '0;
                load_wr.ir_write = 1'b1;
                load_wr.pc_write = 1'b1;

                // R-type with overflow clear then set
                add_row(`OP_RTYPE, `FUNCT_ADD, 3'b000, 0, 8, 4, 4'b0010, 0,
                        {alu_add, sa_a, sb_b, pc_alu_out, br_rd, bd_alu, io_pc});
                add_row(`OP_RTYPE, `FUNCT_SUB, 3'b000, 0, 8, 4, 4'b0010, 0,
                        {alu_sub, sa_a, sb_b, pc_alu_out, br_rd, bd_alu, io_pc});
                add_row(`OP_RTYPE, `FUNCT_AND, 3'b000, 1, 8, 4, 4'b0010, 0,
                        {alu_and, sa_a, sb_b, pc_alu_out, br_rd, bd_alu, io_pc});
                add_row(`OP_RTYPE, `FUNCT_ADD, 3'b100, 0, 12, 5, 4'b0001, 1,
                        {alu_sub, sa_pc, sb_four, pc_load, br_rd, bd_alu, io_ex_ovf});
                add_row(`OP_RTYPE, `FUNCT_SUB, 3'b100, 0, 12, 5, 4'b0001, 1,
                        {alu_sub, sa_pc, sb_four, pc_load, br_rd, bd_alu, io_ex_ovf});
                // Branches with flags as {overflow, eq, gt}
                add_row(`OP_BEQ, 6'h00, 3'b010, 0, 8, 4, 4'b0100, 1,
                        {alu_cmp, sa_a, sb_b, pc_alu_out, br_rd, bd_alu, io_pc});
                add_row(`OP_BEQ, 6'h00, 3'b001, 0, 8, 4, 4'b0000, 0,
                        {alu_cmp, sa_a, sb_b, pc_alu_out, br_rd, bd_alu, io_pc});
                add_row(`OP_BNE, 6'h00, 3'b001, 0, 8, 4, 4'b0100, 1,
                        {alu_cmp, sa_a, sb_b, pc_alu_out, br_rd, bd_alu, io_pc});
                add_row(`OP_BNE, 6'h00, 3'b010, 0, 8, 4, 4'b0000, 0,
                        {alu_cmp, sa_a, sb_b, pc_alu_out, br_rd, bd_alu, io_pc});
                add_row(`OP_BGT, 6'h00, 3'b001, 0, 8, 4, 4'b0100, 1,
                        {alu_cmp, sa_a, sb_b, pc_alu_out, br_rd, bd_alu, io_pc});
                add_row(`OP_BGT, 6'h00, 3'b010, 0, 8, 4, 4'b0000, 0,
                        {alu_cmp, sa_a, sb_b, pc_alu_out, br_rd, bd_alu, io_pc});
                add_row(`OP_BLE, 6'h00, 3'b010, 0, 8, 4, 4'b0100, 1,
                        {alu_cmp, sa_a, sb_b, pc_alu_out, br_rd, bd_alu, io_pc});
                add_row(`OP_BLE, 6'h00, 3'b001, 0, 8, 4, 4'b0000, 0,
                        {alu_cmp, sa_a, sb_b, pc_alu_out, br_rd, bd_alu, io_pc});
                // Memory rows checked on the last memory step
                add_row(`OP_LW, 6'h00, 3'b000, 1, 11, 7, 4'b0010, 0,
                        {alu_add, sa_a, sb_imm, pc_alu_out, br_rt, bd_load, io_alu});
                add_row(`OP_SW, 6'h00, 3'b000, 1, 11, 7, 4'b1000, 0,
                        {alu_add, sa_a, sb_imm, pc_alu_out, br_rd, bd_alu, io_alu});
                add_row(`OP_J, 6'h00, 3'b000, 1, 8, 3, 4'b0100, 1,
                        {alu_add, sa_pc, sb_four, pc_offset, br_rd, bd_alu, io_pc});
                add_row(`OP_JAL, 6'h00, 3'b000, 1, 8, 3, 4'b0110, 1,
                        {alu_add, sa_pc, sb_four, pc_offset, br_ra, bd_pc, io_pc});
                add_row(6'h3f, 6'h00, 3'b000, 1, 10, 3, 4'b0001, 1,   // Unused opcode
                        {alu_sub, sa_pc, sb_four, pc_load, br_rd, bd_alu, io_ex_inex});
                add_row(`OP_RTYPE, `FUNCT_BREAK, 3'b000, 1, 0, 3, 4'b0000, 0,
                        {alu_add, sa_pc, sb_four, pc_alu_out, br_rd, bd_alu, io_pc});

                limit = rows.size() * 16 + 50;
                repeat (5) @(posedge clk);
                #0.5;
                reset = 1'b0;

                // First load after reset
                n = 0;
                do begin
                        @(negedge clk);
                        n++;
                        if (n == 1)
                                check_wr("wr_ctl after reset", wr_ctl, '0);
                end while (!wr_ctl.ir_write && n < 16);
                check_count("cycles to first ir_write", n, 4);
                check_wr("wr_ctl at first ir_write", wr_ctl, load_wr);
                check_sel("sel at first ir_write", sel,
                          {alu_add, sa_pc, sb_four, pc_alu_out, br_rd, bd_alu, io_pc});

                foreach (rows[i])
                        apply_row(i);

                $display("Errors: %0d value, %0d other", value_errs, other_errs);
                if (value_errs + other_errs == 0)
                        $display("TEST OK");
                else
                        $display("TEST FAILED");
                $finish;
        end

endmodule

`default_nettype wire

/* testbench/control_unit_chk.sv */
`timescale 1ns/100ps
`default_nettype none

module control_unit_chk import ctrl_pkg::*; (
        input logic     clk,
        input logic     reset,
        input phase_t   next_phase,
        input ctrl_wr_t wr_ctl
);

        // IR and register bank are never loaded together
        assert property (@(posedge clk) disable iff (reset)
                !(wr_ctl.ir_write && wr_ctl.bank_write))
                else $error("ir_write and bank_write high in the same cycle");

        // Last cycle's next_phase is the phase now driven
        assert property (@(posedge clk) disable iff (reset)
                (wr_ctl.pc_write && $past(next_phase) == ph_fetch) |-> wr_ctl.ir_write)
                else $error("pc_write during fetch without ir_write");

        assert property (@(posedge clk) $fell(reset) |-> (wr_ctl == '0))
                else $error("strobe high in the cycle after reset");

endmodule

bind control_unit control_unit_chk control_unit_chk_i (
        .clk        (clk),
        .reset      (reset),
        .next_phase (next_phase),
        .wr_ctl     (wr_ctl)
);

`default_nettype wire

/* verilog/control_unit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "ctrl_params.svh"

module control_unit import ctrl_pkg::*; (
        input  logic          clk,
        input  logic          reset,
        input  instr_fields_t instr,
        input  alu_flags_t    flags,
        output ctrl_sel_t     sel,
        output ctrl_wr_t      wr_ctl
);

        instr_kind_t        kind;
        phase_t             next_phase;
        logic [`STEP_W-1:0] next_step;
        logic               branch_taken;
        logic               except_code_ovf;

        opcode_decoder opcode_decoder_i (
                .instr (instr),
                .kind  (kind)
        );

        step_sequencer step_sequencer_i (
                .clk             (clk),
                .reset           (reset),
                .kind            (kind),
                .flags           (flags),
                .next_phase      (next_phase),
                .next_step       (next_step),
                .branch_taken    (branch_taken),
                .except_code_ovf (except_code_ovf)
        );

        // Registers against the same edge as the sequencer
        control_word_gen control_word_gen_i (
                .clk             (clk),
                .reset           (reset),
                .next_phase      (next_phase),
                .next_step       (next_step),
                .kind            (kind),
                .branch_taken    (branch_taken),
                .except_code_ovf (except_code_ovf),
                .sel             (sel),
                .wr_ctl          (wr_ctl)
        );

endmodule

`default_nettype wire

/* control/control_word_gen.sv */
`timescale 1ns/100ps
`default_nettype none

`include "ctrl_params.svh"

module control_word_gen import ctrl_pkg::*; (
        input  logic               clk,
        input  logic               reset,
        input  phase_t             next_phase,
        input  logic [`STEP_W-1:0] next_step,
        input  instr_kind_t        kind,
        input  logic               branch_taken,
        input  logic               except_code_ovf,
        output ctrl_sel_t          sel,
        output ctrl_wr_t           wr_ctl
);

        ctrl_sel_t sel_d;
        ctrl_wr_t  wr_d;

        always_comb begin
                // PC plus 4 unless a phase says otherwise
                sel_d.alu_op    = alu_add;
                sel_d.src_a     = sa_pc;
                sel_d.src_b     = sb_four;
                sel_d.pc_src    = pc_alu_out;
                sel_d.bank_reg  = br_rd;
                sel_d.bank_data = bd_alu;
                sel_d.iord      = io_pc;
                wr_d            = '0;

                case (next_phase)
                        ph_fetch: begin
                                if (next_step < 3'd3) begin
                                        wr_d.alu_out_write = 1'b1;
                                end else begin
                                        wr_d.ir_write = 1'b1;
                                        wr_d.pc_write = 1'b1;
                                end
                        end

                        ph_decode: begin
                                sel_d.src_b = sb_offset;        // Branch target ahead of time
                                if (next_step == '0) begin
                                        wr_d.a_write       = 1'b1;
                                        wr_d.b_write       = 1'b1;
                                        wr_d.alu_out_write = 1'b1;
                                end
                        end

                        ph_exec: begin
                                case (kind)
                                        k_add, k_sub, k_and: begin
                                                sel_d.src_a  = sa_a;
                                                sel_d.src_b  = sb_b;
                                                sel_d.alu_op = (kind == k_sub) ? alu_sub :
                                                               (kind == k_and) ? alu_and : alu_add;
                                                if (next_step == '0)
                                                        wr_d.alu_out_write = 1'b1;
                                                else
                                                        wr_d.bank_write = !except_code_ovf;
                                        end
                                        k_beq, k_bne, k_bgt, k_ble: begin
                                                sel_d.alu_op = alu_cmp;
                                                sel_d.src_a  = sa_a;
                                                sel_d.src_b  = sb_b;
                                                if (next_step == 3'd1)
                                                        wr_d.pc_write = branch_taken;
                                        end
                                        k_j, k_jal: begin
                                                sel_d.pc_src = pc_offset;
                                                if (next_step == '0) begin
                                                        wr_d.pc_write = 1'b1;
                                                        if (kind == k_jal) begin
                                                                sel_d.bank_reg  = br_ra;
                                                                sel_d.bank_data = bd_pc;
                                                                wr_d.bank_write = 1'b1;
                                                        end
                                                end
                                        end
                                        default: begin
                                                wr_d = '0;
                                        end
                                endcase
                        end

                        ph_mem: begin
                                // Address is A plus immediate, held in ALU out
                                sel_d.src_a = sa_a;
                                sel_d.src_b = sb_imm;
                                sel_d.iord  = io_alu;
                                case (next_step)
                                        3'd0: wr_d.alu_out_write = 1'b1;
                                        3'd3: wr_d.mem_reg_write = (kind == k_lw);
                                        3'd4: begin
                                                if (kind == k_lw) begin
                                                        sel_d.bank_reg  = br_rt;
                                                        sel_d.bank_data = bd_load;
                                                        wr_d.bank_write = 1'b1;
                                                end else begin
                                                        wr_d.wr = 1'b1;
                                                end
                                        end
                                        default: wr_d = '0;
                                endcase
                        end

                        ph_except: begin
                                sel_d.alu_op = alu_sub;         // EPC gets PC minus 4
                                sel_d.pc_src = pc_load;
                                sel_d.iord   = except_code_ovf ? io_ex_ovf : io_ex_inex;
                                if (next_step < 3'd3) begin
                                        wr_d.epc_write     = 1'b1;
                                        wr_d.mem_reg_write = 1'b1;
                                end else begin
                                        wr_d.pc_write = 1'b1;   // Jump to the vector
                                end
                        end

                        default: begin
                                wr_d = '0;              // Halt
                        end
                endcase
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        sel    <= '0;
                        wr_ctl <= '0;
                end else begin
                        sel    <= sel_d;
                        wr_ctl <= wr_d;
                end
        end

endmodule

`default_nettype wire

/* control/step_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "ctrl_params.svh"

module step_sequencer import ctrl_pkg::*; (
        input  logic               clk,
        input  logic               reset,
        input  instr_kind_t        kind,
        input  alu_flags_t         flags,
        output phase_t             next_phase,
        output logic [`STEP_W-1:0] next_step,
        output logic               branch_taken,
        output logic               except_code_ovf
);

        phase_t             phase;
        logic [`STEP_W-1:0] step;
        logic               ovf_q;              // Overflow latched for the current instruction
        logic               exec_first;

        // ALU is on A and B here, so its flags are valid
        assign exec_first = (phase == ph_exec) && (step == '0);

        always_comb begin
                branch_taken = 1'b0;
                if (exec_first) begin
                        case (kind)
                                k_beq:   branch_taken = flags.eq;
                                k_bne:   branch_taken = !flags.eq;
                                k_bgt:   branch_taken = flags.gt;
                                k_ble:   branch_taken = !flags.gt;
                                default: branch_taken = 1'b0;
                        endcase
                end
        end

        // Live flag on the first execute step, held afterwards
        always_comb begin
                except_code_ovf = ovf_q;
                if (exec_first && (kind == k_add || kind == k_sub))
                        except_code_ovf = flags.overflow;
        end

        always_comb begin
                next_phase = phase;
                next_step  = step + 1'b1;
                case (phase)
                        ph_fetch: begin
                                if (step == 3'd3)       // IR loaded on the 4th cycle
                                        next_phase = ph_decode;
                        end
                        ph_decode: begin
                                if (step == 3'd1) begin
                                        case (kind)
                                                k_add, k_sub, k_and:
                                                        next_phase = ph_exec;
                                                k_beq, k_bne, k_bgt, k_ble:
                                                        next_phase = ph_exec;
                                                k_j, k_jal:
                                                        next_phase = ph_exec;
                                                k_lw, k_sw:
                                                        next_phase = ph_mem;
                                                k_break:
                                                        next_phase = ph_halt;
                                                default:
                                                        next_phase = ph_except;
                                        endcase
                                end
                        end
                        ph_exec: begin
                                if (step == 3'd1)
                                        next_phase = ovf_q ? ph_except : ph_fetch;
                        end
                        ph_mem: begin
                                if (step == 3'd4)       // Four memory cycles plus the writeback
                                        next_phase = ph_fetch;
                        end
                        ph_except: begin
                                if (step == 3'd3)
                                        next_phase = ph_fetch;
                        end
                        ph_halt: begin
                                next_phase = ph_halt;   // Only reset leaves
                        end
                        default: begin
                                next_phase = ph_fetch;
                        end
                endcase

                // Every phase starts at step 0
                if (next_phase != phase || phase == ph_halt)
                        next_step = '0;
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        phase <= ph_fetch;
                        step  <= '0;
                        ovf_q <= 1'b0;
                end else begin
                        phase <= next_phase;
                        step  <= next_step;
                        ovf_q <= (next_phase == ph_fetch) ? 1'b0 : except_code_ovf;
                end
        end

endmodule

`default_nettype wire

/* control/opcode_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

`include "ctrl_params.svh"

module opcode_decoder import ctrl_pkg::*; (
        input  instr_fields_t instr,
        output instr_kind_t   kind
);

        always_comb begin
                case (instr.op)
                        `OP_RTYPE: begin
                                // R-type is told apart by the function field
                                case (instr.funct)
                                        `FUNCT_ADD:   kind = k_add;
                                        `FUNCT_SUB:   kind = k_sub;
                                        `FUNCT_AND:   kind = k_and;
                                        `FUNCT_BREAK: kind = k_break;
                                        default:      kind = k_illegal;
                                endcase
                        end

                        // Branches
                        `OP_BEQ:  kind = k_beq;
                        `OP_BNE:  kind = k_bne;
                        `OP_BGT:  kind = k_bgt;
                        `OP_BLE:  kind = k_ble;

                        // Word memory access
                        `OP_LW:   kind = k_lw;
                        `OP_SW:   kind = k_sw;

                        // Jumps
                        `OP_J:    kind = k_j;
                        `OP_JAL:  kind = k_jal;

                        default:  kind = k_illegal;     // Raises the opcode exception
                endcase
        end

endmodule

`default_nettype wire

/* common/ctrl_pkg.sv */
`default_nettype none

`include "ctrl_params.svh"

package ctrl_pkg;

        typedef struct packed {
                logic [`OP_W-1:0]    op;
                logic [`FUNCT_W-1:0] funct;
        } instr_fields_t;

        typedef struct packed {
                logic overflow;
                logic eq;
                logic gt;
        } alu_flags_t;

        typedef enum logic [3:0] {
                k_add, k_sub, k_and,
                k_beq, k_bne, k_bgt, k_ble,
                k_lw, k_sw,
                k_j, k_jal,
                k_break,
                k_illegal
        } instr_kind_t;

        typedef enum logic [2:0] {
                ph_fetch, ph_decode, ph_exec, ph_mem, ph_except, ph_halt
        } phase_t;

        typedef enum logic [1:0] {alu_add, alu_sub, alu_and, alu_cmp} alu_op_t;

        typedef enum logic [1:0] {sa_pc, sa_a} src_a_t;

        // sb_offset is the shifted immediate used for branch targets
        typedef enum logic [1:0] {sb_b, sb_four, sb_imm, sb_offset} src_b_t;

        typedef enum logic [1:0] {pc_alu_out, pc_offset, pc_load} pc_src_t;

        typedef enum logic [2:0] {br_rt, br_rd, br_ra} bank_reg_t;

        typedef enum logic [2:0] {bd_alu, bd_load, bd_pc} bank_data_t;

        typedef enum logic [`EXC_W-1:0] {
                io_pc      = 3'd0,
                io_alu     = 3'd1,
                io_ex_inex = `EX_OP_INEX,
                io_ex_ovf  = `EX_OVERFLOW
        } iord_t;

        typedef struct packed {
                alu_op_t    alu_op;
                src_a_t     src_a;
                src_b_t     src_b;
                pc_src_t    pc_src;
                bank_reg_t  bank_reg;
                bank_data_t bank_data;
                iord_t      iord;
        } ctrl_sel_t;

        typedef struct packed {
                logic wr;               // Memory write
                logic ir_write;
                logic pc_write;
                logic bank_write;
                logic epc_write;
                logic a_write;
                logic b_write;
                logic alu_out_write;
                logic mem_reg_write;
        } ctrl_wr_t;

endpackage

`default_nettype wire

/* common/ctrl_params.svh */
`ifndef CTRL_PARAMS_SVH
`define CTRL_PARAMS_SVH

// Instruction fields
`define OP_W            6
`define FUNCT_W         6

// Sequencer step counter and exception code widths
`define STEP_W          3
`define EXC_W           3

// Opcodes
`define OP_RTYPE        6'h00
`define OP_J            6'h02
`define OP_JAL          6'h03
`define OP_BEQ          6'h04
`define OP_BNE          6'h05
`define OP_BLE          6'h06
`define OP_BGT          6'h07
`define OP_LW           6'h23
`define OP_SW           6'h2b

// R-type function codes
`define FUNCT_BREAK     6'h0d
`define FUNCT_ADD       6'h20
`define FUNCT_SUB       6'h22
`define FUNCT_AND       6'h24

// Exception vector selects, driven on iord
`define EX_OP_INEX      3'd2
`define EX_OVERFLOW     3'd3

`endif
